/* Bender.yml */
package:
  name: sync_fifo

sources:
  # Design, in compile order
  - fifo_pkg.sv
  - fifo_ram_1r1w.sv
  - fifo_reg_buffer.sv
  - fifo_ram_path.sv
  - fifo_status.sv
  - sync_fifo.sv

  # Testbench
  - target: test
    files:
      - tb_clock.sv
      - tb_sync_fifo.sv

/* fifo_pkg.sv */
`default_nettype none

package fifo_pkg;

  //////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////

  // Word width
  localparam int fifo_data_w = 32;

  // RAM address width, 256 words
  localparam int fifo_addr_w = 8;

  // Prefetch buffer address width, 4 entries
  localparam int prefetch_addr_w = 2;

  //////////////////////////////////////////////////
  // Width types
  //////////////////////////////////////////////////

  // One data word
  typedef logic [fifo_data_w-1:0] fifo_data_t;

  // RAM address
  typedef logic [fifo_addr_w-1:0] fifo_addr_t;

  // Fill level, one bit wider than the address
  typedef logic [fifo_addr_w:0] fifo_level_t;

  // Usable capacity
  // One word below the RAM size
  localparam fifo_level_t fifo_max_level = fifo_level_t'((1 << fifo_addr_w) - 1);

endpackage

`default_nettype wire

/* fifo_ram_1r1w.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_ram_1r1w
  import fifo_pkg::*;
(
  input  logic       clk,

  // Port A, write only
  input  logic       port_a_write_en,
  input  fifo_addr_t port_a_address,
  input  fifo_data_t port_a_data_in,

  // Port B, registered read
  input  fifo_addr_t port_b_address,
  output fifo_data_t port_b_data_out
);

  // Storage array
  fifo_data_t mem [2**fifo_addr_w];

  // Write on port A
  always_ff @(posedge clk) begin
    if (port_a_write_en) begin
      mem[port_a_address] <= port_a_data_in;
    end
  end

  // Read on port B
  // Output register keeps block RAM inference
  always_ff @(posedge clk) begin
    port_b_data_out <= mem[port_b_address];
  end

endmodule

`default_nettype wire

/* fifo_ram_path.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_ram_path
  import fifo_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // Accepted strobes from the status block
  input  logic       write_accept,
  input  logic       read_accept,

  // Data
  input  fifo_data_t wp_data,
  output fifo_data_t rp_data,
  output logic       rp_fifo_empty
);

  // RAM side
  fifo_addr_t  ram_write_address;
  fifo_addr_t  ram_read_address;
  fifo_data_t  ram_read_data;
  fifo_level_t ram_level;
  logic        ram_read;

  // Prefetch buffer side
  logic                     reg_write_enable;
  logic [prefetch_addr_w:0] reg_fill_level;

  //////////////////////////////////////////////////
  // Prefetch control
  //////////////////////////////////////////////////

  // Keep at most 3 words queued, more when a pop frees a slot
  // One read may still be in flight, so the 4th entry absorbs it
  assign ram_read = (ram_level != '0) &&
                    ((reg_fill_level < {1'b0, {prefetch_addr_w{1'b1}}}) || read_accept);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ram_write_address <= '0;
      ram_read_address  <= '0;
      ram_level         <= '0;
      reg_write_enable  <= 1'b0;
    end else begin
      if (write_accept) begin
        ram_write_address <= ram_write_address + 1'b1;
      end
      if (ram_read) begin
        ram_read_address <= ram_read_address + 1'b1;
      end
      // Words in RAM not yet fetched
      if (write_accept && !ram_read) begin
        ram_level <= ram_level + 1'b1;
      end else if (ram_read && !write_accept) begin
        ram_level <= ram_level - 1'b1;
      end
      // RAM data is valid one cycle after the address
      reg_write_enable <= ram_read;
    end
  end

  //////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////

  fifo_ram_1r1w fifo_ram_1r1w_i0 (
    .clk             (clk),
    .port_a_write_en (write_accept),
    .port_a_address  (ram_write_address),
    .port_a_data_in  (wp_data),
    .port_b_address  (ram_read_address),
    .port_b_data_out (ram_read_data)
  );

  // Hides the RAM read delay from the reader
  fifo_reg_buffer #(
    .depth_w (prefetch_addr_w)
  ) fifo_reg_buffer_i0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .wp_write_enable (reg_write_enable),
    .wp_data         (ram_read_data),
    .rp_read_enable  (read_accept),
    .rp_data         (rp_data),
    .rp_fifo_empty   (rp_fifo_empty),
    .sr_fill_level   (reg_fill_level)
  );

  // Depends on the status block holding back writes
  a_ram_level : assert property (@(posedge clk) disable iff (!rst_n)
    ram_level <= fifo_max_level);

endmodule

`default_nettype wire

/* fifo_reg_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_reg_buffer
  import fifo_pkg::*;
#(
  parameter int depth_w = 2
)(
  input  logic             clk,
  input  logic             rst_n,

  // Write side
  input  logic             wp_write_enable,
  input  fifo_data_t       wp_data,

  // Read side
  input  logic             rp_read_enable,
  output fifo_data_t       rp_data,
  output logic             rp_fifo_empty,

  // Entries held
  output logic [depth_w:0] sr_fill_level
);

  // Register array, no reset on payload
  fifo_data_t mem [2**depth_w];

  // Pointers wrap on their own width
  logic [depth_w-1:0] head;
  logic [depth_w-1:0] tail;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wp_write_enable) begin
      mem[tail] <= wp_data;
    end
  end

  //////////////////////////////////////////////////
  // Pointers and level
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head          <= '0;
      tail          <= '0;
      sr_fill_level <= '0;
    end else begin
      if (wp_write_enable) begin
        tail <= tail + 1'b1;
      end
      if (rp_read_enable) begin
        head <= head + 1'b1;
      end
      // Level unchanged on push and pop together
      if (wp_write_enable && !rp_read_enable) begin
        sr_fill_level <= sr_fill_level + 1'b1;
      end else if (rp_read_enable && !wp_write_enable) begin
        sr_fill_level <= sr_fill_level - 1'b1;
      end
    end
  end

  // Oldest entry shown directly
  assign rp_data       = mem[head];
  assign rp_fifo_empty = (sr_fill_level == '0);

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Prefetch control must not push into a full buffer without a pop
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    (sr_fill_level == {1'b1, {depth_w{1'b0}}}) |-> !(wp_write_enable && !rp_read_enable));

  // Status block gates reads on empty
  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
    rp_fifo_empty |-> !rp_read_enable);

endmodule

`default_nettype wire

/* fifo_status.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_status
  import fifo_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // Raw strobes
  input  logic        wp_write_enable,
  input  logic        rp_read_enable,
  input  logic        rp_fifo_empty,
  input  fifo_level_t cr_almost_full_level,

  // Gated strobes
  output logic        write_accept,
  output logic        read_accept,

  // Flags and levels
  output logic        wp_fifo_full,
  output logic        wp_fifo_almost_full,
  output fifo_level_t sr_fill_level,
  output fifo_level_t sr_max_fill_level
);

  //////////////////////////////////////////////////
  // Strobe acceptance
  //////////////////////////////////////////////////

  // A pop in the same cycle frees room for the write
  assign read_accept  = rp_read_enable && !rp_fifo_empty;
  assign write_accept = wp_write_enable && (!wp_fifo_full || read_accept);

  //////////////////////////////////////////////////
  // Level and flags
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sr_fill_level       <= '0;
      sr_max_fill_level   <= '0;
      wp_fifo_full        <= 1'b0;
      wp_fifo_almost_full <= 1'b0;
    end else begin
      // Count words written and not yet read
      if (write_accept && !read_accept) begin
        sr_fill_level <= sr_fill_level + 1'b1;
      end else if (read_accept && !write_accept) begin
        sr_fill_level <= sr_fill_level - 1'b1;
      end
      // High-water mark only rises
      if (sr_fill_level > sr_max_fill_level) begin
        sr_max_fill_level <= sr_fill_level;
      end
      // Flags trail the level by one cycle
      wp_fifo_full        <= (sr_fill_level >= fifo_max_level);
      wp_fifo_almost_full <= (sr_fill_level >= cr_almost_full_level);
    end
  end

  // Flag lag lets a single write through at the limit
  a_level_max : assert property (@(posedge clk) disable iff (!rst_n)
    sr_fill_level <= fifo_max_level + 1'b1);

  // No words counted means nothing left in the prefetch buffer
  a_empty_match : assert property (@(posedge clk) disable iff (!rst_n)
    (sr_fill_level == '0) |-> rp_fifo_empty);

endmodule

`default_nettype wire

/* sync_fifo.f */
fifo_pkg.sv
fifo_ram_1r1w.sv
fifo_reg_buffer.sv
fifo_ram_path.sv
fifo_status.sv
sync_fifo.sv
tb_clock.sv
tb_sync_fifo.sv

/* sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo
  import fifo_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // Write port
  input  logic        wp_write_enable,
  input  fifo_data_t  wp_data,
  output logic        wp_fifo_full,
  output logic        wp_fifo_almost_full,

  // Read port, first word fall through
  input  logic        rp_read_enable,
  output fifo_data_t  rp_data,
  output logic        rp_fifo_empty,

  // Configuration and status
  input  fifo_level_t cr_almost_full_level,
  output fifo_level_t sr_fill_level,
  output fifo_level_t sr_max_fill_level
);

  // Gated strobes between the two halves
  logic write_accept;
  logic read_accept;

  //////////////////////////////////////////////////
  // Status and acceptance
  //////////////////////////////////////////////////

  fifo_status fifo_status_i0 (
    .clk                  (clk),
    .rst_n                (rst_n),
    .wp_write_enable      (wp_write_enable),
    .rp_read_enable       (rp_read_enable),
    .rp_fifo_empty        (rp_fifo_empty),
    .cr_almost_full_level (cr_almost_full_level),
    .write_accept         (write_accept),
    .read_accept          (read_accept),
    .wp_fifo_full         (wp_fifo_full),
    .wp_fifo_almost_full  (wp_fifo_almost_full),
    .sr_fill_level        (sr_fill_level),
    .sr_max_fill_level    (sr_max_fill_level)
  );

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  fifo_ram_path fifo_ram_path_i0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .write_accept  (write_accept),
    .read_accept   (read_accept),
    .wp_data       (wp_data),
    .rp_data       (rp_data),
    .rp_fifo_empty (rp_fifo_empty)
  );

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  // Half of the 100 ns period
  parameter int half_period = 50
)(
  output logic clk
);

  // Free running, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #(half_period) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

/* tb_sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sync_fifo
  import fifo_pkg::*;
();

  // All tests together take about 1400 cycles
  localparam int timeout_cycles = 20000;
  localparam logic [16:0] lfsr_seed = 17'd65605;

  logic        clk;
  logic        rst_n;
  logic        wp_write_enable;
  fifo_data_t  wp_data;
  logic        rp_read_enable;
  fifo_level_t cr_almost_full_level;
  fifo_data_t  rp_data;
  logic        rp_fifo_empty;
  logic        wp_fifo_full;
  logic        wp_fifo_almost_full;
  fifo_level_t sr_fill_level;
  fifo_level_t sr_max_fill_level;

  // Reference model of accepted words
  fifo_data_t  model_q[$];
  int          model_max;
  // Full flag as the model expects it in the current cycle
  logic        model_full;
  logic [16:0] lfsr_state;
  int          error_count;
  int          test_count;
  int          test_start_errors;
  int          cycle_count;

  tb_clock tb_clock_i0 (
    .clk (clk)
  );

  sync_fifo UUT (
    .clk                  (clk),
    .rst_n                (rst_n),
    .wp_write_enable      (wp_write_enable),
    .wp_data              (wp_data),
    .wp_fifo_full         (wp_fifo_full),
    .wp_fifo_almost_full  (wp_fifo_almost_full),
    .rp_read_enable       (rp_read_enable),
    .rp_data              (rp_data),
    .rp_fifo_empty        (rp_fifo_empty),
    .cr_almost_full_level (cr_almost_full_level),
    .sr_fill_level        (sr_fill_level),
    .sr_max_fill_level    (sr_max_fill_level)
  );

  //////////////////////////////////////////////////
  // Random bits and reporting
  //////////////////////////////////////////////////

  // 17-bit Fibonacci LFSR with taps 17 and 14
  function automatic logic [16:0] lfsr_next(input logic [16:0] state);
    return {state[15:0], state[16] ^ state[13]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("error: %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
    error_count++;
  endtask

  task automatic report_failure(input string what);
    $display("%s at %0t", what, $time);
    error_count++;
  endtask

  task automatic start_test();
    test_start_errors = error_count;
  endtask

  task automatic finish_test(input string name);
    test_count++;
    if (error_count == test_start_errors) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, error_count - test_start_errors);
    end
  endtask

  //////////////////////////////////////////////////
  // Bus cycles
  //////////////////////////////////////////////////

  task automatic apply_reset();
    @(posedge clk);
    rst_n           <= 1'b0;
    wp_write_enable <= 1'b0;
    rp_read_enable  <= 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    model_q.delete();
    model_max  = 0;
    model_full = 1'b0;
  endtask

  // Drive on the rising edge and sample at the falling edge
  task automatic drive_cycle(input logic wr, input fifo_data_t data, input logic rd);
    logic       read_ok;
    logic       write_ok;
    int         level_now;
    fifo_data_t expected_word;
    @(posedge clk);
    wp_write_enable <= wr;
    wp_data         <= data;
    rp_read_enable  <= rd;
    @(negedge clk);
    // Level covers strobes accepted up to the last cycle
    level_now = model_q.size();
    if (sr_fill_level !== fifo_level_t'(level_now)) begin
      report_mismatch("sr_fill_level", level_now, sr_fill_level);
    end
    if (wp_fifo_full !== model_full) begin
      report_mismatch("wp_fifo_full", model_full, wp_fifo_full);
    end
    // Pop only while data shows
    read_ok  = rd && !rp_fifo_empty;
    // Push needs room or a pop in the same cycle
    write_ok = wr && (!model_full || read_ok);
    if (read_ok) begin
      if (model_q.size() == 0) begin
        report_failure("read accepted with no word left in the model");
      end else begin
        expected_word = model_q.pop_front();
        if (rp_data !== expected_word) begin
          report_mismatch("rp_data", expected_word, rp_data);
        end
      end
    end
    if (write_ok) begin
      model_q.push_back(data);
    end
    if (model_q.size() > model_max) begin
      model_max = model_q.size();
    end
    // Full flag follows this cycle's level one cycle later
    model_full = (level_now >= fifo_max_level);
  endtask

  task automatic idle_cycles(input int count);
    repeat (count) drive_cycle(1'b0, '0, 1'b0);
  endtask

  // Write to visible data takes up to 4 cycles
  task automatic wait_for_data(input int limit);
    int waited;
    waited = 0;
    while (rp_fifo_empty && waited < limit) begin
      idle_cycles(1);
      waited++;
    end
    if (rp_fifo_empty) begin
      report_failure("rp_fifo_empty stayed high after a write");
    end
  endtask

  // Read until the model is empty
  task automatic drain_fifo();
    int guard;
    guard = 0;
    while (model_q.size() > 0 && guard < 1000) begin
      drive_cycle(1'b0, '0, 1'b1);
      guard++;
    end
    idle_cycles(1);
    if (model_q.size() != 0) begin
      report_failure("FIFO did not drain");
    end
    if (rp_fifo_empty !== 1'b1) begin
      report_mismatch("rp_fifo_empty", 1, rp_fifo_empty);
    end
    if (sr_fill_level !== '0) begin
      report_mismatch("sr_fill_level", 0, sr_fill_level);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic check_reset_values();
    start_test();
    if (rp_fifo_empty !== 1'b1) begin
      report_mismatch("rp_fifo_empty", 1, rp_fifo_empty);
    end
    if (wp_fifo_full !== 1'b0) begin
      report_mismatch("wp_fifo_full", 0, wp_fifo_full);
    end
    if (wp_fifo_almost_full !== 1'b0) begin
      report_mismatch("wp_fifo_almost_full", 0, wp_fifo_almost_full);
    end
    if (sr_fill_level !== '0) begin
      report_mismatch("sr_fill_level", 0, sr_fill_level);
    end
    if (sr_max_fill_level !== '0) begin
      report_mismatch("sr_max_fill_level", 0, sr_max_fill_level);
    end
    finish_test("after_reset");
  endtask

  task automatic pass_single_word();
    fifo_data_t word;
    start_test();
    word = random_bits(32);
    drive_cycle(1'b1, word, 1'b0);
    wait_for_data(4);
    if (rp_data !== word) begin
      report_mismatch("rp_data", word, rp_data);
    end
    drive_cycle(1'b0, '0, 1'b1);
    idle_cycles(1);
    if (rp_fifo_empty !== 1'b1) begin
      report_mismatch("rp_fifo_empty", 1, rp_fifo_empty);
    end
    if (sr_fill_level !== '0) begin
      report_mismatch("sr_fill_level", 0, sr_fill_level);
    end
    finish_test("single_word");
  endtask

  task automatic fill_and_overflow();
    start_test();
    for (int i = 0; i < fifo_max_level; i++) begin
      drive_cycle(1'b1, random_bits(32), 1'b0);
    end
    // Full flag trails the level by one cycle
    idle_cycles(2);
    if (wp_fifo_full !== 1'b1) begin
      report_mismatch("wp_fifo_full", 1, wp_fifo_full);
    end
    if (sr_fill_level !== fifo_max_level) begin
      report_mismatch("sr_fill_level", fifo_max_level, sr_fill_level);
    end
    // Extra word must be dropped
    drive_cycle(1'b1, random_bits(32), 1'b0);
    idle_cycles(1);
    if (sr_fill_level !== fifo_max_level) begin
      report_mismatch("sr_fill_level", fifo_max_level, sr_fill_level);
    end
    drain_fifo();
    finish_test("fill_overflow");
  endtask

  task automatic almost_full_threshold();
    start_test();
    @(posedge clk);
    cr_almost_full_level <= 9'd10;
    for (int i = 0; i < 9; i++) begin
      drive_cycle(1'b1, random_bits(32), 1'b0);
    end
    idle_cycles(2);
    if (wp_fifo_almost_full !== 1'b0) begin
      report_mismatch("wp_fifo_almost_full", 0, wp_fifo_almost_full);
    end
    // Flag rises two cycles after the 10th word
    drive_cycle(1'b1, random_bits(32), 1'b0);
    idle_cycles(1);
    if (wp_fifo_almost_full !== 1'b0) begin
      report_mismatch("wp_fifo_almost_full", 0, wp_fifo_almost_full);
    end
    idle_cycles(1);
    if (wp_fifo_almost_full !== 1'b1) begin
      report_mismatch("wp_fifo_almost_full", 1, wp_fifo_almost_full);
    end
    drain_fifo();
    finish_test("almost_full");
  endtask

  task automatic mixed_traffic();
    logic wr;
    logic rd;
    start_test();
    // Fresh high-water mark for this test
    apply_reset();
    for (int i = 0; i < 600; i++) begin
      // Writes 3 in 4 and reads 1 in 2 while data shows
      wr = (random_bits(2) != 0);
      rd = random_bits(1) && !rp_fifo_empty;
      drive_cycle(wr, random_bits(32), rd);
    end
    idle_cycles(2);
    if (sr_max_fill_level !== fifo_level_t'(model_max)) begin
      report_mismatch("sr_max_fill_level", model_max, sr_max_fill_level);
    end
    drain_fifo();
    finish_test("mixed_traffic");
  endtask

  //////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////

  initial begin : main
    rst_n                <= 1'b0;
    wp_write_enable      <= 1'b0;
    wp_data              <= '0;
    rp_read_enable       <= 1'b0;
    cr_almost_full_level <= 9'd200;
    lfsr_state  = lfsr_seed;
    error_count = 0;
    test_count  = 0;
    model_max   = 0;
    model_full  = 1'b0;
    apply_reset();
    check_reset_values();
    pass_single_word();
    fill_and_overflow();
    almost_full_threshold();
    mixed_traffic();
    $display("tests %0d, errors %0d, cycles %0d", test_count, error_count, cycle_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("run stopped by timeout after %0d cycles", cycle_count);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
